/* common/switch_pkg.sv */
package switch_pkg;

    // port count of the ingress stage.
    localparam int NUM_PORTS = 2;
    localparam int PORT_W    = 1;          // source port index width.

    // datapath word.
    localparam int WORD_W    = 16;

    // per-port receive FIFO, 64 words.
    localparam int FIFO_AW    = 6;
    localparam int FIFO_DEPTH = 1 << FIFO_AW;

    // shared packet memory, 512 words, wraps at the end.
    localparam int MEM_AW    = 9;
    localparam int MEM_DEPTH = 1 << MEM_AW;

    // header word layout.
    //   [15:7] length in words, header included
    //   [6:4]  priority
    //   [3:0]  destination port
    localparam int LEN_W    = 9;
    localparam int PRIO_W   = 3;
    localparam int DEST_W   = 4;
    localparam int LEN_LSB  = 7;
    localparam int PRIO_LSB = 4;
    localparam int DEST_LSB = 0;

    // the frontend stops the sender this many words short of a full FIFO.
    localparam int PAUSE_MARGIN = 2;

endpackage

/* port_wr_frontend/port_wr_frontend.sv */
`timescale 1ns/10ps

module port_wr_frontend (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wr_sop,
    input  logic                          wr_eop,
    input  logic                          wr_vld,
    input  logic [switch_pkg::WORD_W-1:0] wr_data,
    output logic                          pause,
    input  logic                          match_suc,
    output logic                          match_enable,
    output logic [switch_pkg::PRIO_W-1:0] new_prior,
    output logic                          xfer_data_vld,
    output logic [switch_pkg::WORD_W-1:0] xfer_data,
    output logic                          end_of_packet
);
    import switch_pkg::*;

    typedef enum logic [1:0] {RX_IDLE, RX_HDR, RX_BODY, RX_TAIL} rx_state_t;
    typedef enum logic [1:0] {XF_IDLE, XF_RUN, XF_WAIT} xf_state_t;

    rx_state_t          rx_state;
    rx_state_t          rx_state_nxt;
    xf_state_t          xf_state;

    logic [WORD_W-1:0]  fifo_mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] wr_ptr_nxt;
    logic [FIFO_AW-1:0] xfer_ptr;
    logic [FIFO_AW-1:0] xfer_ptr_pls;
    logic [FIFO_AW-1:0] end_ptr;      // one past the last word of the packet in flight.
    logic [FIFO_AW-1:0] req_ptr;      // header of the oldest packet not yet granted.
    logic [FIFO_AW-1:0] fill_nxt;
    logic [FIFO_AW:0]   req_cnt;      // headers received, not yet granted.
    logic [FIFO_AW:0]   req_cnt_nxt;
    logic [LEN_W-1:0]   hdr_len;
    logic [LEN_W-1:0]   rx_len;
    logic [LEN_W-1:0]   rx_cnt;
    logic               hdr_acc;
    logic               body_acc;
    logic               last_acc;
    logic               fifo_wr;
    logic               pst_suc;
    logic               xfer_start;

    // receive side.
    assign hdr_len  = wr_data[LEN_LSB +: LEN_W];
    assign hdr_acc  = wr_vld && (rx_state == RX_HDR || (rx_state == RX_IDLE && wr_sop));
    assign body_acc = wr_vld && rx_state == RX_BODY;
    assign fifo_wr  = hdr_acc || body_acc;
    assign last_acc = (hdr_acc && hdr_len <= LEN_W'(1)) ||
                      (body_acc && rx_cnt + LEN_W'(1) >= rx_len);   // count reached length.

    always_comb begin
        rx_state_nxt = rx_state;
        if (last_acc) begin
            rx_state_nxt = wr_eop ? RX_IDLE : RX_TAIL;   // eop may trail the last word.
        end else if (hdr_acc) begin
            rx_state_nxt = RX_BODY;
        end else if (rx_state == RX_IDLE && wr_sop) begin
            rx_state_nxt = RX_HDR;                       // header comes on a later vld.
        end else if (rx_state == RX_TAIL && wr_eop) begin
            rx_state_nxt = RX_IDLE;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_state <= RX_IDLE;
            rx_cnt   <= '0;
            wr_ptr   <= '0;
        end else begin
            rx_state <= rx_state_nxt;
            wr_ptr   <= wr_ptr_nxt;
            if (hdr_acc) begin
                rx_cnt <= LEN_W'(1);
            end else if (body_acc) begin
                rx_cnt <= rx_cnt + LEN_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_wr) begin
            fifo_mem[wr_ptr] <= wr_data;
        end
        if (hdr_acc) begin
            rx_len <= hdr_len;
        end
    end

    assign wr_ptr_nxt = wr_ptr + FIFO_AW'(fifo_wr);

    // match request, one per header still waiting for a grant.
    assign req_cnt_nxt  = req_cnt + {{FIFO_AW{1'b0}}, hdr_acc} - {{FIFO_AW{1'b0}}, match_suc};
    assign match_enable = req_cnt != '0;
    assign new_prior    = fifo_mem[req_ptr][PRIO_LSB +: PRIO_W];   // priority of oldest request.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_cnt <= '0;
            req_ptr <= '0;
        end else begin
            req_cnt <= req_cnt_nxt;
            if (match_suc) begin
                req_ptr <= req_ptr + fifo_mem[req_ptr][LEN_LSB +: FIFO_AW];   // skip to next header.
            end
        end
    end

    // transfer side.
    assign xfer_ptr_pls = xfer_ptr + FIFO_AW'(1);
    assign xfer_start   = xf_state == XF_IDLE && (match_suc || pst_suc);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            xf_state      <= XF_IDLE;
            xfer_ptr      <= '0;
            end_ptr       <= '0;
            pst_suc       <= 1'b0;
            xfer_data_vld <= 1'b0;
            end_of_packet <= 1'b0;
        end else begin
            xfer_data_vld <= 1'b0;
            end_of_packet <= 1'b0;
            if (xfer_start) begin
                pst_suc <= 1'b0;
            end else if (match_suc) begin
                pst_suc <= 1'b1;                         // grant seen while still busy.
            end
            case (xf_state)
                XF_IDLE: begin
                    if (xfer_start) begin
                        end_ptr  <= xfer_ptr + fifo_mem[xfer_ptr][LEN_LSB +: FIFO_AW];
                        xf_state <= XF_RUN;
                    end
                end
                XF_RUN: begin
                    xfer_data_vld <= 1'b1;
                    xfer_ptr      <= xfer_ptr_pls;
                    if (xfer_ptr_pls == end_ptr) begin
                        end_of_packet <= 1'b1;
                        xf_state      <= XF_IDLE;
                    end else if (xfer_ptr_pls == wr_ptr_nxt) begin
                        xf_state <= XF_WAIT;             // caught the writer.
                    end
                end
                XF_WAIT: begin
                    if (xfer_ptr != wr_ptr) begin
                        xf_state <= XF_RUN;
                    end
                end
                default: xf_state <= XF_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (xf_state == XF_RUN) begin
            xfer_data <= fifo_mem[xfer_ptr];
        end
    end

    // pause works on next-state values, so only one word can still be in flight.
    assign fill_nxt = wr_ptr_nxt - xfer_ptr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pause <= 1'b0;
        end else begin
            pause <= (fill_nxt >= FIFO_AW'(FIFO_DEPTH - PAUSE_MARGIN)) ||
                     ((rx_state_nxt == RX_IDLE || rx_state_nxt == RX_HDR) &&
                      req_cnt_nxt != '0);
        end
    end

endmodule

/* rtl/match_ctrl.sv */
`timescale 1ns/10ps

module match_ctrl (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic [switch_pkg::NUM_PORTS-1:0]                     match_enable,
    input  logic [switch_pkg::NUM_PORTS*switch_pkg::PRIO_W-1:0]  new_prior,
    input  logic [switch_pkg::NUM_PORTS-1:0]                     end_of_packet,
    output logic [switch_pkg::NUM_PORTS-1:0]                     match_suc
);
    import switch_pkg::*;

    typedef enum logic {MC_IDLE, MC_BUSY} mc_state_t;

    mc_state_t         state;
    logic [PORT_W-1:0] last_port;    // port granted last, owns the grant while busy.
    logic [PORT_W-1:0] pick;
    logic [PRIO_W-1:0] best_prior;
    logic              found;

    // scan starts after the last granted port, so equal priorities rotate.
    always_comb begin
        int idx;
        found      = 1'b0;
        pick       = last_port;
        best_prior = '0;
        for (int i = 1; i <= NUM_PORTS; i++) begin
            idx = (int'(last_port) + i) % NUM_PORTS;
            if (match_enable[idx] &&
                (!found || new_prior[idx*PRIO_W +: PRIO_W] > best_prior)) begin
                found      = 1'b1;                       // strictly higher wins, ties keep order.
                pick       = PORT_W'(idx);
                best_prior = new_prior[idx*PRIO_W +: PRIO_W];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= MC_IDLE;
            last_port <= '0;
            match_suc <= '0;
        end else begin
            match_suc <= '0;                             // single-cycle pulse.
            case (state)
                MC_IDLE: begin
                    if (found) begin
                        match_suc[pick] <= 1'b1;
                        last_port       <= pick;
                        state           <= MC_BUSY;
                    end
                end
                MC_BUSY: begin
                    if (end_of_packet[last_port]) begin
                        state <= MC_IDLE;                // owner finished its packet.
                    end
                end
                default: state <= MC_IDLE;
            endcase
        end
    end

endmodule

/* rtl/pkt_store.sv */
`timescale 1ns/10ps

module pkt_store (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic [switch_pkg::NUM_PORTS-1:0]                     xfer_data_vld,
    input  logic [switch_pkg::NUM_PORTS*switch_pkg::WORD_W-1:0]  xfer_data,
    input  logic [switch_pkg::NUM_PORTS-1:0]                     end_of_packet,
    output logic                                                 desc_vld,
    output logic [switch_pkg::PORT_W-1:0]                        desc_src,
    output logic [switch_pkg::DEST_W-1:0]                        desc_dest,
    output logic [switch_pkg::PRIO_W-1:0]                        desc_prior,
    output logic [switch_pkg::MEM_AW-1:0]                        desc_addr,
    output logic [switch_pkg::LEN_W-1:0]                         desc_len,
    input  logic [switch_pkg::MEM_AW-1:0]                        rd_addr,
    output logic [switch_pkg::WORD_W-1:0]                        rd_data
);
    import switch_pkg::*;

    logic [WORD_W-1:0] pkt_mem [MEM_DEPTH];
    logic [MEM_AW-1:0] wr_ptr;
    logic              in_pkt;       // inside a packet, next word is not a header.
    logic              in_vld;
    logic              in_eop;
    logic              in_first;
    logic [WORD_W-1:0] in_data;
    logic [PORT_W-1:0] in_src;

    // descriptor fields of the packet being stored.
    logic [PORT_W-1:0] cur_src;
    logic [DEST_W-1:0] cur_dest;
    logic [PRIO_W-1:0] cur_prior;
    logic [MEM_AW-1:0] cur_addr;
    logic [LEN_W-1:0]  cur_len;
    logic [PORT_W-1:0] pkt_src;
    logic [DEST_W-1:0] pkt_dest;
    logic [PRIO_W-1:0] pkt_prior;
    logic [MEM_AW-1:0] pkt_addr;
    logic [LEN_W-1:0]  pkt_len;

    // only the granted port is ever valid, so an OR merge is enough.
    always_comb begin
        in_vld  = 1'b0;
        in_eop  = 1'b0;
        in_data = '0;
        in_src  = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (xfer_data_vld[i]) begin
                in_vld  = 1'b1;
                in_eop  = in_eop | end_of_packet[i];
                in_data = in_data | xfer_data[i*WORD_W +: WORD_W];
                in_src  = PORT_W'(i);
            end
        end
    end

    assign in_first = in_vld && !in_pkt;

    // header word parsed on the fly, later words reuse the latched fields.
    assign pkt_src   = in_first ? in_src : cur_src;
    assign pkt_dest  = in_first ? in_data[DEST_LSB +: DEST_W] : cur_dest;
    assign pkt_prior = in_first ? in_data[PRIO_LSB +: PRIO_W] : cur_prior;
    assign pkt_addr  = in_first ? wr_ptr : cur_addr;
    assign pkt_len   = in_first ? in_data[LEN_LSB +: LEN_W] : cur_len;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            in_pkt   <= 1'b0;
            desc_vld <= 1'b0;
        end else begin
            desc_vld <= in_vld && in_eop;                // one cycle after the last word.
            if (in_vld) begin
                wr_ptr <= wr_ptr + MEM_AW'(1);           // wraps at the end of memory.
                in_pkt <= !in_eop;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_vld) begin
            pkt_mem[wr_ptr] <= in_data;
        end
        if (in_first) begin
            cur_src   <= pkt_src;
            cur_dest  <= pkt_dest;
            cur_prior <= pkt_prior;
            cur_addr  <= pkt_addr;
            cur_len   <= pkt_len;
        end
        if (in_vld && in_eop) begin
            desc_src   <= pkt_src;                       // held until the next packet ends.
            desc_dest  <= pkt_dest;
            desc_prior <= pkt_prior;
            desc_addr  <= pkt_addr;
            desc_len   <= pkt_len;
        end
        rd_data <= pkt_mem[rd_addr];                     // registered read port.
    end

endmodule

/* rtl/switch_ingress_top.sv */
`timescale 1ns/10ps

module switch_ingress_top (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic [switch_pkg::NUM_PORTS-1:0]                     wr_sop,
    input  logic [switch_pkg::NUM_PORTS-1:0]                     wr_eop,
    input  logic [switch_pkg::NUM_PORTS-1:0]                     wr_vld,
    input  logic [switch_pkg::NUM_PORTS*switch_pkg::WORD_W-1:0]  wr_data,
    output logic [switch_pkg::NUM_PORTS-1:0]                     pause,
    output logic                                                 desc_vld,
    output logic [switch_pkg::PORT_W-1:0]                        desc_src,
    output logic [switch_pkg::DEST_W-1:0]                        desc_dest,
    output logic [switch_pkg::PRIO_W-1:0]                        desc_prior,
    output logic [switch_pkg::MEM_AW-1:0]                        desc_addr,
    output logic [switch_pkg::LEN_W-1:0]                         desc_len,
    input  logic [switch_pkg::MEM_AW-1:0]                        rd_addr,
    output logic [switch_pkg::WORD_W-1:0]                        rd_data
);
    import switch_pkg::*;

    logic [NUM_PORTS-1:0]        match_enable;     // per-port request level.
    logic [NUM_PORTS*PRIO_W-1:0] new_prior;
    logic [NUM_PORTS-1:0]        match_suc;        // grant pulse.
    logic [NUM_PORTS-1:0]        xfer_data_vld;
    logic [NUM_PORTS*WORD_W-1:0] xfer_data;
    logic [NUM_PORTS-1:0]        end_of_packet;    // to both arbiter and store.

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        port_wr_frontend i_port_wr_frontend (
            .clk           (clk),
            .rst_n         (rst_n),
            .wr_sop        (wr_sop[p]),
            .wr_eop        (wr_eop[p]),
            .wr_vld        (wr_vld[p]),
            .wr_data       (wr_data[p*WORD_W +: WORD_W]),
            .pause         (pause[p]),
            .match_suc     (match_suc[p]),
            .match_enable  (match_enable[p]),
            .new_prior     (new_prior[p*PRIO_W +: PRIO_W]),
            .xfer_data_vld (xfer_data_vld[p]),
            .xfer_data     (xfer_data[p*WORD_W +: WORD_W]),
            .end_of_packet (end_of_packet[p])
        );
    end

    match_ctrl i_match_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .match_enable  (match_enable),
        .new_prior     (new_prior),
        .end_of_packet (end_of_packet),
        .match_suc     (match_suc)
    );

    pkt_store i_pkt_store (
        .clk           (clk),
        .rst_n         (rst_n),
        .xfer_data_vld (xfer_data_vld),
        .xfer_data     (xfer_data),
        .end_of_packet (end_of_packet),
        .desc_vld      (desc_vld),
        .desc_src      (desc_src),
        .desc_dest     (desc_dest),
        .desc_prior    (desc_prior),
        .desc_addr     (desc_addr),
        .desc_len      (desc_len),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data)
    );

endmodule

/* verif/switch_ingress_assert.sv */
`timescale 1ns/10ps

module switch_ingress_assert (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [switch_pkg::NUM_PORTS-1:0] onehot,    // one bit per port.
    input  logic                             pulse      // single-cycle strobe.
);

    int fail_cnt = 0;                                   // summed into the final result.

    // grants and store writes come from one port at a time.
    a_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(onehot))
        else begin
            $error("more than one port active in the same cycle");
            fail_cnt++;
        end

    // a strobe never lasts two cycles.
    a_pulse: assert property (@(posedge clk) disable iff (!rst_n) pulse |=> !pulse)
        else begin
            $error("strobe high on two consecutive cycles");
            fail_cnt++;
        end

endmodule

bind match_ctrl switch_ingress_assert i_match_assert (
    .clk    (clk),
    .rst_n  (rst_n),
    .onehot (match_suc),
    .pulse  (|end_of_packet)
);

bind pkt_store switch_ingress_assert i_store_assert (
    .clk    (clk),
    .rst_n  (rst_n),
    .onehot (xfer_data_vld),
    .pulse  (desc_vld)
);

/* verif/switch_checker.sv */
`timescale 1ns/10ps

module switch_checker (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             desc_vld,
    input  logic [switch_pkg::PORT_W-1:0]    desc_src,
    input  logic [switch_pkg::DEST_W-1:0]    desc_dest,
    input  logic [switch_pkg::PRIO_W-1:0]    desc_prior,
    input  logic [switch_pkg::MEM_AW-1:0]    desc_addr,
    input  logic [switch_pkg::LEN_W-1:0]     desc_len,
    input  logic                             rd_check,  // read-back sweep in progress.
    input  logic [switch_pkg::MEM_AW-1:0]    rd_addr,
    input  logic [switch_pkg::WORD_W-1:0]    rd_data
);
    import switch_pkg::*;

    logic [WORD_W-1:0] hdr_q  [NUM_PORTS][$];        // headers sent, oldest first.
    logic [WORD_W-1:0] word_q [NUM_PORTS][$];        // every word sent, header included.
    int                first_q [$];                  // expected source of the next grant.
    logic [WORD_W-1:0] shadow [MEM_DEPTH];           // expected packet memory contents.
    logic              shadow_vld [MEM_DEPTH];
    logic [MEM_AW-1:0] run_addr = '0;                // where the next packet should land.
    logic [MEM_AW-1:0] addr_d = '0;
    logic              chk_d = 1'b0;
    int                pending = 0;                  // packets sent, no descriptor yet.
    int                errors = 0;
    int                desc_cnt = 0;
    int                rd_words = 0;

    // expected {dest, prior, len, addr} from the header layout and the running address.
    function automatic logic [24:0] expect_desc(input logic [15:0] hdr,
                                                input logic [8:0] addr);
        return {hdr[3:0], hdr[6:4], hdr[15:7], addr};
    endfunction

    task automatic push_header(input int src, input logic [WORD_W-1:0] hdr);
        hdr_q[src].push_back(hdr);
        pending++;
    endtask

    task automatic push_word(input int src, input logic [WORD_W-1:0] word);
        word_q[src].push_back(word);
    endtask

    task automatic expect_first(input int src);
        first_q.push_back(src);
    endtask

    task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    initial begin
        for (int i = 0; i < MEM_DEPTH; i++) begin
            shadow_vld[i] = 1'b0;
        end
    end

    always @(posedge clk) begin
        logic [24:0] exp;
        logic [15:0] hdr;
        int          src;
        // rd_data answers the address seen one edge earlier.
        if (chk_d && shadow_vld[addr_d]) begin
            rd_words++;
            compare("rd_data", rd_data, shadow[addr_d]);
        end
        chk_d  <= rd_check;
        addr_d <= rd_addr;
        if (rst_n && desc_vld) begin
            src = int'(desc_src);
            desc_cnt++;
            if (first_q.size() != 0) begin
                compare("desc_src", 16'(desc_src), 16'(first_q.pop_front()));
            end
            if (hdr_q[src].size() == 0) begin
                $display("descriptor from port %0d arrived with no packet outstanding", src);
                errors++;
            end else begin
                hdr = hdr_q[src].pop_front();
                pending--;
                exp = expect_desc(hdr, run_addr);
                compare("desc_dest", 16'(desc_dest), 16'(exp[24:21]));
                compare("desc_prior", 16'(desc_prior), 16'(exp[20:18]));
                compare("desc_len", 16'(desc_len), 16'(exp[17:9]));
                compare("desc_addr", 16'(desc_addr), 16'(exp[8:0]));
                for (int k = 0; k < int'(exp[17:9]); k++) begin
                    shadow[exp[8:0] + MEM_AW'(k)]     = word_q[src].pop_front();
                    shadow_vld[exp[8:0] + MEM_AW'(k)] = 1'b1;   // newer packets overwrite.
                end
                run_addr = exp[8:0] + exp[17:9];                // wraps at 512.
            end
        end
    end

endmodule

/* verif/tb_switch_ingress.sv */
`timescale 1ns/10ps

module tb_switch_ingress;
    import switch_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int MAX_LEN    = 40;
    localparam int N_STREAM   = 16;                  // packets per port in the stream test.
    localparam int N_PAIRS    = 4;
    localparam int N_LONG     = 3;
    localparam int NUM_PKTS   = 1 + 2 * N_STREAM + 2 * N_PAIRS + 2 * N_LONG;
    localparam longint WATCHDOG_NS =
        longint'(NUM_PKTS * (MAX_LEN + 20) + 2 * (MEM_DEPTH + 4) + 10) * CLK_PERIOD;

    logic                        clk;
    logic                        rst_n;
    logic [NUM_PORTS-1:0]        wr_sop;
    logic [NUM_PORTS-1:0]        wr_eop;
    logic [NUM_PORTS-1:0]        wr_vld;
    logic [NUM_PORTS*WORD_W-1:0] wr_data;
    logic [NUM_PORTS-1:0]        pause;
    logic                        desc_vld;
    logic [PORT_W-1:0]           desc_src;
    logic [DEST_W-1:0]           desc_dest;
    logic [PRIO_W-1:0]           desc_prior;
    logic [MEM_AW-1:0]           desc_addr;
    logic [LEN_W-1:0]            desc_len;
    logic [MEM_AW-1:0]           rd_addr;
    logic [WORD_W-1:0]           rd_data;
    logic                        rd_check;
    integer                      seed;
    int                          test_num = 1;
    int                          err_base = 0;

    switch_ingress_top i_switch_ingress_top (.*);

    switch_checker i_switch_checker (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic int rand_range(input int lo, input int hi);
        int r;
        r = $random(seed);
        return lo + ((r & 32'h7fff_ffff) % (hi - lo + 1));
    endfunction

    function automatic int total_errors();
        return i_switch_checker.errors
             + i_switch_ingress_top.i_match_ctrl.i_match_assert.fail_cnt
             + i_switch_ingress_top.i_pkt_store.i_store_assert.fail_cnt;
    endfunction

    // one word per edge while pause is low, header first.
    task automatic send_pkt(input int port, input int len, input int prio, input int dest);
        logic [WORD_W-1:0] word;
        int                i;
        i = 0;
        while (i < len) begin
            @(posedge clk);
            if (pause[port]) begin
                wr_vld[port] <= 1'b0;                    // hold off while paused.
                wr_sop[port] <= 1'b0;
                wr_eop[port] <= 1'b0;
            end else begin
                if (i == 0) begin
                    word = {9'(len), 3'(prio), 4'(dest)};
                    i_switch_checker.push_header(port, word);
                end else begin
                    word = 16'($random(seed));
                end
                i_switch_checker.push_word(port, word);
                wr_vld[port]                   <= 1'b1;
                wr_sop[port]                   <= (i == 0);
                wr_eop[port]                   <= (i == len - 1);
                wr_data[port*WORD_W +: WORD_W] <= word;
                i++;
            end
        end
    endtask

    // len_fix 0 and prio_fix -1 pick random values.
    task automatic send_stream(input int port, input int count, input int len_fix,
                               input int prio_fix);
        int len;
        int prio;
        for (int n = 0; n < count; n++) begin
            len  = (len_fix > 0) ? len_fix : rand_range(2, MAX_LEN);
            prio = (prio_fix >= 0) ? prio_fix : rand_range(0, 7);
            send_pkt(port, len, prio, rand_range(0, 15));
        end
        @(posedge clk);
        wr_vld[port] <= 1'b0;
        wr_sop[port] <= 1'b0;
        wr_eop[port] <= 1'b0;
    endtask

    task automatic drain();
        while (i_switch_checker.pending != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
    endtask

    task automatic read_back();
        for (int a = 0; a < MEM_DEPTH; a++) begin
            @(posedge clk);
            rd_check <= 1'b1;
            rd_addr  <= MEM_AW'(a);
        end
        @(posedge clk);
        rd_check <= 1'b0;
        repeat (3) @(posedge clk);                       // last compare lands two edges later.
    endtask

    task automatic end_test(input string name);
        int errs;
        drain();
        errs = total_errors() - err_base;
        $display("test %0d %s: %s", test_num, name,
                 (errs == 0) ? "ok" : $sformatf("%0d errors", errs));
        test_num++;
        err_base = total_errors();
    endtask

    initial begin
        int p0;
        int p1;
        int len0;
        int len1;
        int first;
        int last_grant;
        seed       = 32'h12df_4de3;
        last_grant = 0;
        rst_n      = 1'b0;
        wr_sop     = '0;
        wr_eop     = '0;
        wr_vld     = '0;
        wr_data    = '0;
        rd_addr    = '0;
        rd_check   = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        send_stream(0, 1, 5, 3);                         // lands at address 0.
        end_test("single packet on port 0");

        fork
            send_stream(0, N_STREAM, 0, -1);
            send_stream(1, N_STREAM, 0, -1);
        join
        end_test("random streams on both ports");

        // even pairs have distinct priorities, odd pairs equal ones.
        // port 0 wins pair 0 and port 1 wins pair 2, so each tie follows a different owner.
        for (int k = 0; k < N_PAIRS; k++) begin
            p0    = (k % 4 == 0) ? rand_range(4, 7) : rand_range(0, 3);
            p1    = (k % 2 == 1) ? p0 : (p0 ^ 7);
            len0  = rand_range(2, MAX_LEN);
            len1  = rand_range(2, MAX_LEN);
            first = (p0 > p1) ? 0 : (p1 > p0) ? 1 : 1 - last_grant;
            last_grant = 1 - first;                      // the loser is granted second.
            i_switch_checker.expect_first(first);
            fork
                send_stream(0, 1, len0, p0);
                send_stream(1, 1, len1, p1);
            join
            drain();
        end
        end_test("priority and round robin");

        // port 0 keeps the grant, port 1 must be paused.
        fork
            send_stream(0, N_LONG, MAX_LEN, 7);
            send_stream(1, N_LONG, MAX_LEN, 0);
        join
        drain();
        read_back();
        end_test("long packets under pause");

        read_back();
        end_test("memory read-back");

        $display("%0d tests, %0d descriptors, %0d words read back, %0d errors",
                 test_num - 1, i_switch_checker.desc_cnt, i_switch_checker.rd_words,
                 total_errors());
        if (total_errors() == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // watchdog sized from the packet count and the read-back sweeps.
    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, traffic did not drain", WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* sources.f */
common/switch_pkg.sv
port_wr_frontend/port_wr_frontend.sv
rtl/match_ctrl.sv
rtl/pkt_store.sv
rtl/switch_ingress_top.sv
verif/switch_ingress_assert.sv
verif/switch_checker.sv
verif/tb_switch_ingress.sv

/* Bender.yml */
package:
  name: switch_ingress

sources:
  - common/switch_pkg.sv
  - port_wr_frontend/port_wr_frontend.sv
  - rtl/match_ctrl.sv
  - rtl/pkt_store.sv
  - rtl/switch_ingress_top.sv
  - target: simulation
    files:
      - verif/switch_ingress_assert.sv
      - verif/switch_checker.sv
      - verif/tb_switch_ingress.sv
